/* run.sh */
#!/bin/sh
# build and run the decode stage testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module idu_tb \
  -Mdir "$BUILD_DIR" -o idu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/idu_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^All tests passed!$' "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

/* testbench/idu_properties.sv */
// decode stage properties: bound assertions on the top-level control outputs
`timescale 1ns/1ps

module idu_properties (
  input logic                             i_clk,
  input logic                             i_rst,
  input logic                             i_inst_valid,
  input logic [isa_pkg::XLEN-1:0]         i_imm,
  input logic                             i_alu_a_pc,
  input logic [ctrl_pkg::ALU_OP_W-1:0]    i_alu_op,
  input logic                             i_reg_wr,
  input logic                             i_mem_rd,
  input logic                             i_mem_wr,
  input logic [ctrl_pkg::MEM_OP_W-1:0]    i_mem_op,
  input logic                             i_br_en,
  input logic [ctrl_pkg::BR_FUNC_W-1:0]   i_br_func,
  input logic                             i_invalid_inst
);
  import ctrl_pkg::*;

  int fail_count = 0;  // assertion failures so far

  a_mem_excl: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_mem_rd && i_mem_wr))
    else begin
      fail_count++;
      $error("memory read and write enabled together");
    end

  // only jumps write a link register
  a_jump_link: assert property (@(posedge i_clk) disable iff (i_rst)
    i_br_en |-> (i_reg_wr == (i_br_func <= BR_JALR)))
    else begin
      fail_count++;
      $error("branch write enable does not match jump type");
    end

  a_idle: assert property (@(posedge i_clk) disable iff (i_rst)
    !i_inst_valid |-> (!i_reg_wr && !i_mem_rd && !i_mem_wr && !i_br_en && !i_alu_a_pc &&
                       i_alu_op == ALU_NONE && i_mem_op == MEM_NONE && i_imm == '0 &&
                       !i_invalid_inst))
    else begin
      fail_count++;
      $error("control active without a valid instruction");
    end

endmodule

bind idu_top idu_properties idu_props_i (
  .i_clk          (i_clk),
  .i_rst          (i_rst),
  .i_inst_valid   (i_inst_valid),
  .i_imm          (o_imm),
  .i_alu_a_pc     (o_alu_a_pc),
  .i_alu_op       (o_alu_op),
  .i_reg_wr       (o_reg_wr),
  .i_mem_rd       (o_mem_rd),
  .i_mem_wr       (o_mem_wr),
  .i_mem_op       (o_mem_op),
  .i_br_en        (o_br_en),
  .i_br_func      (o_br_func),
  .i_invalid_inst (o_invalid_inst)
);

/* testbench/idu_model.svh */
// decode stage reference model: expected controls and immediate, plus a register file mirror
`ifndef IDU_MODEL_SVH
`define IDU_MODEL_SVH

typedef struct packed {
  logic [63:0] imm;
  logic        alu_a_pc;
  logic [1:0]  alu_b_src;
  logic [4:0]  alu_op;
  logic        word_cut;
  logic        reg_wr;
  logic        mem_rd;
  logic        mem_wr;
  logic [2:0]  mem_op;
  logic        br_en;
  logic [2:0]  br_func;
  logic        invalid;
} exp_ctrl_t;

localparam int FMT_NONE = 0;
localparam int FMT_I    = 1;
localparam int FMT_U    = 2;
localparam int FMT_S    = 3;
localparam int FMT_B    = 4;
localparam int FMT_J    = 5;

logic [63:0] ref_regs [32];

function automatic exp_ctrl_t idle_ctrl();
  exp_ctrl_t e;
  e = '0;
  e.alu_op = 5'd31;  // none
  e.mem_op = 3'd7;   // none
  return e;
endfunction

// alt selects sub or sra
function automatic logic [4:0] alu_code_for(input logic [2:0] f3, input logic alt);
  case (f3)
    3'd0:    return alt ? 5'd1 : 5'd0;
    3'd1:    return 5'd7;
    3'd2:    return 5'd2;
    3'd3:    return 5'd3;
    3'd4:    return 5'd4;
    3'd5:    return alt ? 5'd9 : 5'd8;
    3'd6:    return 5'd6;
    default: return 5'd5;
  endcase
endfunction

function automatic logic [63:0] sext_imm(input logic [31:0] w, input int fmt);
  case (fmt)
    FMT_I:   return 64'($signed(w[31:20]));
    FMT_U:   return 64'($signed({w[31:12], 12'h000}));
    FMT_S:   return 64'($signed({w[31:25], w[11:7]}));
    FMT_B:   return 64'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
    FMT_J:   return 64'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
    default: return 64'h0;
  endcase
endfunction

function automatic exp_ctrl_t decode_model(input logic [31:0] word, input logic valid);
  exp_ctrl_t   e;
  logic [31:0] w;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic        known;
  logic        jump;
  logic        alt_ok;
  int          fmt;
  w = valid ? word : 32'h0;
  f3 = w[14:12];
  f7 = w[31:25];
  alt_ok = (f3 == 3'd0) || (f3 == 3'd5);
  e = idle_ctrl();
  known = 1'b0;
  jump = 1'b0;
  fmt = FMT_NONE;
  case (w[6:0])
    7'b0110111: begin  // lui
      known = 1'b1;
      fmt = FMT_U;
      e.alu_op = 5'd15;
    end
    7'b0010111: begin  // auipc
      known = 1'b1;
      fmt = FMT_U;
      e.alu_a_pc = 1'b1;
      e.alu_op = 5'd0;
    end
    7'b1101111: begin  // jal
      known = 1'b1;
      fmt = FMT_J;
      jump = 1'b1;
    end
    7'b1100111: begin  // jalr
      known = (f3 == 3'd0);
      fmt = FMT_I;
      jump = 1'b1;
      e.br_func = 3'd1;
    end
    7'b1100011: begin  // funct3 2 and 3 unused
      known = (f3[2:1] != 2'b01);
      fmt = FMT_B;
      e.br_en = 1'b1;
      e.br_func = f3[2] ? f3 : f3 + 3'd2;
    end
    7'b0000011: begin  // loads
      known = (f3 != 3'd7);
      fmt = FMT_I;
      e.mem_rd = 1'b1;
      e.alu_op = 5'd0;
      e.mem_op = {f3[1:0], f3[2]};  // unsigned sizes take the odd codes
    end
    7'b0100011: begin  // stores
      known = !f3[2];
      fmt = FMT_S;
      e.mem_wr = 1'b1;
      e.alu_op = 5'd0;
      e.mem_op = {f3[1:0], 1'b0};
    end
    7'b0010011: begin  // op-imm, 6-bit shamt
      fmt = FMT_I;
      case (f3)
        3'd1:    known = (f7[6:1] == 6'b000000);
        3'd5:    known = (f7[6:1] == 6'b000000) || (f7[6:1] == 6'b010000);
        default: known = 1'b1;
      endcase
      e.alu_op = alu_code_for(f3, (f3 == 3'd5) && w[30]);
    end
    7'b0011011: begin  // op-imm-32
      fmt = FMT_I;
      e.word_cut = 1'b1;
      case (f3)
        3'd0:    known = 1'b1;
        3'd1:    known = (f7 == 7'h00);
        3'd5:    known = (f7 == 7'h00) || (f7 == 7'h20);
        default: known = 1'b0;
      endcase
      e.alu_op = alu_code_for(f3, (f3 == 3'd5) && w[30]);
    end
    7'b0110011: begin
      known = (f7 == 7'h00) || ((f7 == 7'h20) && alt_ok);
      e.alu_op = alu_code_for(f3, w[30]);
    end
    7'b0111011: begin  // op-32
      known = ((f3 == 3'd0) || (f3 == 3'd1) || (f3 == 3'd5)) &&
              ((f7 == 7'h00) || ((f7 == 7'h20) && alt_ok));
      e.word_cut = 1'b1;
      e.alu_op = alu_code_for(f3, w[30]);
    end
    default: known = 1'b0;
  endcase
  if (jump) begin
    e.alu_a_pc = 1'b1;
    e.alu_op = 5'd0;
    e.alu_b_src = 2'd2;  // link value pc + 4
    e.br_en = 1'b1;
  end else if (fmt == FMT_I || fmt == FMT_U || fmt == FMT_S) begin
    e.alu_b_src = 2'd1;
  end
  e.reg_wr = !e.mem_wr && (jump || !e.br_en);
  if (!known || w == 32'h0) begin
    e = idle_ctrl();
    e.invalid = (w != 32'h0);
  end else begin
    e.imm = sext_imm(w, fmt);
  end
  return e;
endfunction

task automatic update_ref_regs(input logic rst, input logic wen, input logic [4:0] waddr,
                               input logic [63:0] wdata);
  if (rst) begin
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = 64'h0;
    end
  end else if (wen && waddr != 5'd0) begin
    ref_regs[waddr] = wdata;
  end
endtask

function automatic logic [63:0] expected_read(input logic [4:0] addr);
  return (addr == 5'd0) ? 64'h0 : ref_regs[addr];
endfunction

`endif

/* testbench/idu_tb.sv */
// decode stage testbench: random and directed stimulus checked against a reference model
`timescale 1ns/1ps

module idu_tb;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_RANDOM   = 2000;
  localparam int NREGS        = 32;
  localparam int TOTAL_CYCLES = 2 * RESET_CYCLES + 4 * NREGS + NUM_RANDOM;
  localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 200) * CLK_PERIOD;

  logic        clk;
  logic        rst;
  logic [31:0] inst;
  logic        inst_valid;
  logic        wb_wen;
  logic [4:0]  wb_waddr;
  logic [63:0] wb_wdata;
  logic [4:0]  rd;
  logic [63:0] rs1_data;
  logic [63:0] rs2_data;
  logic [63:0] imm;
  logic        alu_a_pc;
  logic [1:0]  alu_b_src;
  logic [4:0]  alu_op;
  logic        word_cut;
  logic        reg_wr;
  logic        mem_rd;
  logic        mem_wr;
  logic [2:0]  mem_op;
  logic        br_en;
  logic [2:0]  br_func;
  logic        invalid_inst;

  int    seed;
  string test_name;

  `include "idu_model.svh"

  tb_clock #(.PERIOD_NS(CLK_PERIOD)) clk_gen_i (.o_clk(clk));

  idu_top idu_top_i (
    .i_clk          (clk),
    .i_rst          (rst),
    .i_inst         (inst),
    .i_inst_valid   (inst_valid),
    .i_wb_wen       (wb_wen),
    .i_wb_waddr     (wb_waddr),
    .i_wb_wdata     (wb_wdata),
    .o_rd           (rd),
    .o_rs1_data     (rs1_data),
    .o_rs2_data     (rs2_data),
    .o_imm          (imm),
    .o_alu_a_pc     (alu_a_pc),
    .o_alu_b_src    (alu_b_src),
    .o_alu_op       (alu_op),
    .o_word_cut     (word_cut),
    .o_reg_wr       (reg_wr),
    .o_mem_rd       (mem_rd),
    .o_mem_wr       (mem_wr),
    .o_mem_op       (mem_op),
    .o_br_en        (br_en),
    .o_br_func      (br_func),
    .o_invalid_inst (invalid_inst)
  );

  always @(posedge clk) begin
    update_ref_regs(rst, wb_wen, wb_waddr, wb_wdata);
  end

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("Error: %s %s expected %h actual %h", test_name, what, expected, actual);
      $display("Test failures found");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic check_outputs();
    exp_ctrl_t   e;
    logic [31:0] g;
    e = decode_model(inst, inst_valid);
    g = inst_valid ? inst : 32'h0;
    check_value("rd", 64'(g[11:7]), 64'(rd));
    check_value("rs1_data", expected_read(g[19:15]), rs1_data);
    check_value("rs2_data", expected_read(g[24:20]), rs2_data);
    check_value("imm", e.imm, imm);
    check_value("alu_a_pc", 64'(e.alu_a_pc), 64'(alu_a_pc));
    check_value("alu_b_src", 64'(e.alu_b_src), 64'(alu_b_src));
    check_value("alu_op", 64'(e.alu_op), 64'(alu_op));
    check_value("word_cut", 64'(e.word_cut), 64'(word_cut));
    check_value("reg_wr", 64'(e.reg_wr), 64'(reg_wr));
    check_value("mem_rd", 64'(e.mem_rd), 64'(mem_rd));
    check_value("mem_wr", 64'(e.mem_wr), 64'(mem_wr));
    check_value("mem_op", 64'(e.mem_op), 64'(mem_op));
    check_value("br_en", 64'(e.br_en), 64'(br_en));
    if (e.br_en) begin
      check_value("br_func", 64'(e.br_func), 64'(br_func));
    end
    check_value("invalid", 64'(e.invalid), 64'(invalid_inst));
  endtask

  // drive at a falling edge, check just before the next one
  task automatic run_cycle(input logic [31:0] word, input logic valid, input logic wen,
                           input logic [4:0] waddr, input logic [63:0] wdata);
    inst = word;
    inst_valid = valid;
    wb_wen = wen;
    wb_waddr = waddr;
    wb_wdata = wdata;
    @(negedge clk);
    check_outputs();
  endtask

  function automatic logic [31:0] encode_add(input logic [4:0] dst, input logic [4:0] src1,
                                             input logic [4:0] src2);
    return {7'h00, src2, src1, 3'b000, dst, 7'b0110011};
  endfunction

  // random fields, then opcode and funct bits forced to a kept instruction
  function automatic logic [31:0] make_template(input int kind, input logic [31:0] r);
    logic [31:0] w;
    w = r;
    case (kind)
      1: w[6:0] = 7'b0010111;  // auipc
      2: w[6:0] = 7'b1101111;  // jal
      3: begin
        w[6:0] = 7'b1100111;
        w[14:12] = 3'b000;
      end
      4: begin
        w[6:0] = 7'b1100011;
        w[13] = w[13] & w[14];  // avoid funct3 2 and 3
      end
      5: begin
        w[6:0] = 7'b0000011;
        w[12] = w[12] & ~(w[14] & w[13]);
      end
      6: begin
        w[6:0] = 7'b0100011;
        w[14] = 1'b0;
      end
      7: begin
        w[6:0] = 7'b0010011;
        if (w[14:12] == 3'd1 || w[14:12] == 3'd5) begin
          w[31:26] = {1'b0, w[30] & w[14], 4'b0000};
        end
      end
      8, 10: begin
        w[6:0] = (kind == 8) ? 7'b0011011 : 7'b0111011;
        case (w[13:12])
          2'b00:   w[14:12] = 3'b000;
          2'b01:   w[14:12] = 3'b001;
          default: w[14:12] = 3'b101;
        endcase
        if (kind == 10 || w[14:12] != 3'b000) begin
          w[31:25] = {1'b0, w[30] & (w[14:12] != 3'b001), 5'b00000};
        end
      end
      9: begin
        w[6:0] = 7'b0110011;
        w[31:25] = {1'b0, w[30] & (w[14:12] == 3'd0 || w[14:12] == 3'd5), 5'b00000};
      end
      default: w[6:0] = 7'b0110111;  // lui
    endcase
    return w;
  endfunction

  task automatic apply_reset();
    logic [31:0] r;
    test_name = "reset";
    rst = 1'b1;
    inst_valid = 1'b0;
    for (int n = 0; n < RESET_CYCLES; n++) begin
      r = $random(seed);
      wb_wen = r[0];  // dropped while in reset
      wb_waddr = r[5:1];
      wb_wdata = {r, ~r};
      @(negedge clk);
    end
    rst = 1'b0;
    wb_wen = 1'b0;
  endtask

  task automatic sweep_regs_zero(input string label);
    for (int r = 0; r < NREGS; r++) begin
      test_name = $sformatf("%s x%0d", label, r);
      run_cycle(encode_add(5'd1, 5'(r), 5'(NREGS - 1 - r)), 1'b1, 1'b0, 5'd0, 64'h0);
      check_value("rs1 after reset", 64'h0, rs1_data);
      check_value("rs2 after reset", 64'h0, rs2_data);
    end
  endtask

  task automatic run_random(input int count);
    logic [31:0] r;
    logic [31:0] sel;
    logic [31:0] hi;
    logic [31:0] word;
    for (int n = 0; n < count; n++) begin
      test_name = $sformatf("random %0d", n);
      r = $random(seed);
      sel = $random(seed);
      hi = $random(seed);
      if (sel[31:26] == 6'd0) begin
        word = 32'h0;
      end else if (sel[3:0] < 4'd12) begin
        word = make_template(int'(sel[15:8]) % 11, r);
      end else begin
        word = r;  // mostly outside the kept set
      end
      run_cycle(word, sel[19:16] != 4'd0, sel[20], sel[25:21], {hi, r});
    end
  endtask

  task automatic sweep_writeback();
    logic [31:0] hi;
    logic [31:0] lo;
    logic [63:0] data;
    for (int r = 0; r < NREGS; r++) begin
      test_name = $sformatf("writeback x%0d", r);
      hi = $random(seed);
      lo = $random(seed);
      data = {hi, lo};
      run_cycle(32'h0, 1'b0, 1'b1, 5'(r), data);
      run_cycle(encode_add(5'(r), 5'(r), 5'(r)), 1'b1, 1'b0, 5'd0, 64'h0);
      check_value("rs1 readback", (r == 0) ? 64'h0 : data, rs1_data);
      check_value("rs2 readback", (r == 0) ? 64'h0 : data, rs2_data);
    end
  endtask

  initial begin
    seed = 29190;
    test_name = "init";
    rst = 1'b1;
    inst = 32'h0;
    inst_valid = 1'b0;
    wb_wen = 1'b0;
    wb_waddr = 5'd0;
    wb_wdata = 64'h0;
    apply_reset();
    sweep_regs_zero("after first reset");
    run_random(NUM_RANDOM);
    sweep_writeback();
    apply_reset();
    sweep_regs_zero("after second reset");
    if (idu_top_i.idu_props_i.fail_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Test failures found");
      $fatal(1, "%0d assertion failures", idu_top_i.idu_props_i.fail_count);
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Test failures found");
    $fatal(1, "watchdog expired before the tests finished");
  end

endmodule

/* testbench/tb_clock.sv */
// testbench clock generator: free-running clock of a set period
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS = 40
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

endmodule

/* verilog.f */
+incdir+testbench
verilog/isa_pkg.sv
verilog/ctrl_pkg.sv
verilog/decode_if.sv
verilog/inst_decoder.sv
verilog/imm_gen.sv
verilog/ctrl_gen.sv
verilog/gpr_file.sv
verilog/idu_top.sv
testbench/tb_clock.sv
testbench/idu_properties.sv
testbench/idu_tb.sv

/* verilog/ctrl_gen.sv */
// control generator: alu, memory, branch and write-enable controls from the decoded op
`timescale 1ns/1ps

module ctrl_gen (
  decode_if.ctrl               dec,
  output logic                 o_alu_a_pc,
  output ctrl_pkg::alu_b_src_e o_alu_b_src,
  output ctrl_pkg::alu_op_e    o_alu_op,
  output logic                 o_word_cut,
  output logic                 o_reg_wr,
  output logic                 o_mem_rd,
  output logic                 o_mem_wr,
  output ctrl_pkg::mem_op_e    o_mem_op,
  output logic                 o_br_en,
  output ctrl_pkg::br_func_e   o_br_func
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  logic is_load;
  logic is_store;
  logic is_branch;
  logic is_jump;
  logic is_imm_alu;
  logic is_kept;

  assign is_load    = dec.op inside {OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU};
  assign is_store   = dec.op inside {OP_SB, OP_SH, OP_SW, OP_SD};
  assign is_branch  = dec.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
  assign is_jump    = dec.op inside {OP_JAL, OP_JALR};
  assign is_imm_alu = dec.op inside {OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
                                     OP_SLLI, OP_SRLI, OP_SRAI,
                                     OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW};
  assign is_kept    = !(dec.op inside {OP_NONE, OP_INVALID});

  assign o_reg_wr    = is_kept && !is_store && !is_branch;
  assign o_alu_a_pc  = is_jump || (dec.op == OP_AUIPC);
  assign o_alu_b_src = is_jump ? B_FOUR :
                       (is_load || is_store || is_imm_alu ||
                        dec.op inside {OP_LUI, OP_AUIPC}) ? B_IMM : B_RS2;
  assign o_word_cut  = dec.op inside {OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
                                      OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW};
  assign o_mem_rd    = is_load;
  assign o_mem_wr    = is_store;
  assign o_br_en     = is_branch || is_jump;

  always_comb begin
    case (dec.op)
      OP_LUI:                                  o_alu_op = ALU_COPY_IMM;
      OP_AUIPC, OP_JAL, OP_JALR,
      OP_ADDI, OP_ADD, OP_ADDIW, OP_ADDW:      o_alu_op = ALU_ADD;
      OP_SUB, OP_SUBW:                         o_alu_op = ALU_SUB;
      OP_SLT, OP_SLTI:                         o_alu_op = ALU_SLT;
      OP_SLTU, OP_SLTIU:                       o_alu_op = ALU_SLTU;
      OP_XOR, OP_XORI:                         o_alu_op = ALU_XOR;
      OP_AND, OP_ANDI:                         o_alu_op = ALU_AND;
      OP_OR, OP_ORI:                           o_alu_op = ALU_OR;
      OP_SLL, OP_SLLI, OP_SLLW, OP_SLLIW:      o_alu_op = ALU_SLL;
      OP_SRL, OP_SRLI, OP_SRLW, OP_SRLIW:      o_alu_op = ALU_SRL;
      OP_SRA, OP_SRAI, OP_SRAW, OP_SRAIW:      o_alu_op = ALU_SRA;
      default: o_alu_op = (is_load || is_store) ? ALU_ADD : ALU_NONE;  // address calc
    endcase
  end

  always_comb begin
    case (dec.op)
      OP_LB, OP_SB: o_mem_op = MEM_B;
      OP_LBU:       o_mem_op = MEM_BU;
      OP_LH, OP_SH: o_mem_op = MEM_H;
      OP_LHU:       o_mem_op = MEM_HU;
      OP_LW, OP_SW: o_mem_op = MEM_W;
      OP_LWU:       o_mem_op = MEM_WU;
      OP_LD, OP_SD: o_mem_op = MEM_D;
      default:      o_mem_op = MEM_NONE;
    endcase
  end

  always_comb begin
    case (dec.op)
      OP_JALR: o_br_func = BR_JALR;
      OP_BEQ:  o_br_func = BR_BEQ;
      OP_BNE:  o_br_func = BR_BNE;
      OP_BLT:  o_br_func = BR_BLT;
      OP_BGE:  o_br_func = BR_BGE;
      OP_BLTU: o_br_func = BR_BLTU;
      OP_BGEU: o_br_func = BR_BGEU;
      default: o_br_func = BR_JAL;  // jal, or don't care when br_en low
    endcase
  end

endmodule

/* verilog/ctrl_pkg.sv */
// control package: encodings of the decode stage control outputs
package ctrl_pkg;

  localparam int ALU_OP_W    = 5;
  localparam int ALU_B_SRC_W = 2;
  localparam int MEM_OP_W    = 3;
  localparam int BR_FUNC_W   = 3;

  typedef enum logic [ALU_OP_W-1:0] {
    ALU_ADD      = 5'd0,
    ALU_SUB      = 5'd1,
    ALU_SLT      = 5'd2,
    ALU_SLTU     = 5'd3,
    ALU_XOR      = 5'd4,
    ALU_AND      = 5'd5,
    ALU_OR       = 5'd6,
    ALU_SLL      = 5'd7,
    ALU_SRL      = 5'd8,
    ALU_SRA      = 5'd9,
    ALU_COPY_IMM = 5'd15,  // lui passes the immediate
    ALU_NONE     = 5'd31
  } alu_op_e;

  typedef enum logic [ALU_B_SRC_W-1:0] {
    B_RS2  = 2'd0,
    B_IMM  = 2'd1,
    B_FOUR = 2'd2  // return address pc + 4
  } alu_b_src_e;

  // stores use the signed codes
  typedef enum logic [MEM_OP_W-1:0] {
    MEM_B, MEM_BU, MEM_H, MEM_HU, MEM_W, MEM_WU, MEM_D, MEM_NONE
  } mem_op_e;

  typedef enum logic [BR_FUNC_W-1:0] {
    BR_JAL, BR_JALR, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
  } br_func_e;

endpackage

/* verilog/decode_if.sv */
// decode interface: decoded instruction from decoder to immediate and control generators
`timescale 1ns/1ps

interface decode_if;
  import isa_pkg::*;

  inst_op_e              op;
  logic [REG_ADDR_W-1:0] rd;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [INST_W-1:0]     inst;  // raw word, immediate bits

  modport src  (output op, rd, rs1, rs2, inst);
  modport imm  (input op, inst);
  modport ctrl (input op, rs1);

endinterface

/* verilog/gpr_file.sv */
// integer register file: two combinational reads, one synchronous write, x0 hardwired zero
`timescale 1ns/1ps

module gpr_file #(
  parameter int ADDR_WIDTH = 5,
  parameter int DATA_WIDTH = 64
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic [ADDR_WIDTH-1:0] i_raddr1,
  input  logic [ADDR_WIDTH-1:0] i_raddr2,
  input  logic                  i_wen,
  input  logic [ADDR_WIDTH-1:0] i_waddr,
  input  logic [DATA_WIDTH-1:0] i_wdata,
  output logic [DATA_WIDTH-1:0] o_rdata1,
  output logic [DATA_WIDTH-1:0] o_rdata2
);

  localparam int NREGS = 2**ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] regs [NREGS];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin  // x0 writes dropped
      regs[i_waddr] <= i_wdata;
    end
  end

  // no bypass, same-cycle read sees old value
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

/* verilog/idu_top.sv */
// instruction decode unit: rv64i decoder, immediate and control generators, register file
`timescale 1ns/1ps

module idu_top (
  input  logic                             i_clk,
  input  logic                             i_rst,
  input  logic [isa_pkg::INST_W-1:0]       i_inst,
  input  logic                             i_inst_valid,
  input  logic                             i_wb_wen,
  input  logic [isa_pkg::REG_ADDR_W-1:0]   i_wb_waddr,
  input  logic [isa_pkg::XLEN-1:0]         i_wb_wdata,
  output logic [isa_pkg::REG_ADDR_W-1:0]   o_rd,
  output logic [isa_pkg::XLEN-1:0]         o_rs1_data,
  output logic [isa_pkg::XLEN-1:0]         o_rs2_data,
  output logic [isa_pkg::XLEN-1:0]         o_imm,
  output logic                             o_alu_a_pc,
  output logic [ctrl_pkg::ALU_B_SRC_W-1:0] o_alu_b_src,
  output logic [ctrl_pkg::ALU_OP_W-1:0]    o_alu_op,
  output logic                             o_word_cut,
  output logic                             o_reg_wr,
  output logic                             o_mem_rd,
  output logic                             o_mem_wr,
  output logic [ctrl_pkg::MEM_OP_W-1:0]    o_mem_op,
  output logic                             o_br_en,
  output logic [ctrl_pkg::BR_FUNC_W-1:0]   o_br_func,
  output logic                             o_invalid_inst
);
  import isa_pkg::*;

  decode_if dec ();

  inst_decoder u_dec (
    .i_inst       (i_inst),
    .i_inst_valid (i_inst_valid),
    .dec          (dec.src),
    .o_invalid    (o_invalid_inst)
  );

  imm_gen u_imm (
    .dec   (dec.imm),
    .o_imm (o_imm)
  );

  ctrl_gen u_ctrl (
    .dec         (dec.ctrl),
    .o_alu_a_pc  (o_alu_a_pc),
    .o_alu_b_src (o_alu_b_src),
    .o_alu_op    (o_alu_op),
    .o_word_cut  (o_word_cut),
    .o_reg_wr    (o_reg_wr),
    .o_mem_rd    (o_mem_rd),
    .o_mem_wr    (o_mem_wr),
    .o_mem_op    (o_mem_op),
    .o_br_en     (o_br_en),
    .o_br_func   (o_br_func)
  );

  gpr_file #(
    .ADDR_WIDTH (REG_ADDR_W),
    .DATA_WIDTH (XLEN)
  ) u_gprs (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_raddr1 (dec.rs1),
    .i_raddr2 (dec.rs2),
    .i_wen    (i_wb_wen),   // write-back from the end of the pipe
    .i_waddr  (i_wb_waddr),
    .i_wdata  (i_wb_wdata),
    .o_rdata1 (o_rs1_data),
    .o_rdata2 (o_rs2_data)
  );

  assign o_rd = dec.rd;

endmodule

/* verilog/imm_gen.sv */
// immediate generator: sign-extended 64-bit immediate for i, u, s, b and j formats
`timescale 1ns/1ps

module imm_gen (
  decode_if.imm                    dec,
  output logic [isa_pkg::XLEN-1:0] o_imm
);
  import isa_pkg::*;

  typedef enum logic [2:0] {FMT_NONE, FMT_I, FMT_U, FMT_S, FMT_B, FMT_J} imm_fmt_e;

  imm_fmt_e          fmt;
  logic [INST_W-1:0] w;

  assign w = dec.inst;

  always_comb begin
    if (dec.op inside {OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU, OP_JALR,
                       OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
                       OP_SLLI, OP_SRLI, OP_SRAI,
                       OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW})
      fmt = FMT_I;
    else if (dec.op inside {OP_LUI, OP_AUIPC}) fmt = FMT_U;
    else if (dec.op inside {OP_SB, OP_SH, OP_SW, OP_SD}) fmt = FMT_S;
    else if (dec.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU}) fmt = FMT_B;
    else if (dec.op == OP_JAL) fmt = FMT_J;
    else fmt = FMT_NONE;  // r-type, none, invalid
  end

  always_comb begin
    case (fmt)
      FMT_I:   o_imm = {{(XLEN-12){w[31]}}, w[31:20]};
      FMT_U:   o_imm = {{(XLEN-32){w[31]}}, w[31:12], 12'b0};
      FMT_S:   o_imm = {{(XLEN-12){w[31]}}, w[31:25], w[11:7]};
      FMT_B:   o_imm = {{(XLEN-12){w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      FMT_J:   o_imm = {{(XLEN-20){w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      default: o_imm = '0;
    endcase
  end

endmodule

/* verilog/inst_decoder.sv */
// instruction decoder: matches opcode and funct fields of an rv64i word to one instruction
`timescale 1ns/1ps

module inst_decoder (
  input  logic [isa_pkg::INST_W-1:0] i_inst,
  input  logic                       i_inst_valid,
  decode_if.src                      dec,
  output logic                       o_invalid
);
  import isa_pkg::*;

  logic [INST_W-1:0]   inst_g;
  logic [OPCODE_W-1:0] opcode;
  logic [FUNCT3_W-1:0] funct3;
  logic [FUNCT7_W-1:0] funct7;
  logic                f7_base;
  logic                f7_alt;
  logic                sh_base;
  logic                sh_alt;
  inst_op_e            op;

  assign inst_g = i_inst_valid ? i_inst : '0;  // idle slot reads as zero
  assign opcode = inst_g[6:0];
  assign funct3 = inst_g[14:12];
  assign funct7 = inst_g[31:25];

  assign f7_base = (funct7 == F7_BASE);
  assign f7_alt  = (funct7 == F7_ALT);
  assign sh_base = (funct7[6:1] == F7_BASE[6:1]);  // 6-bit shamt, bit 25 free
  assign sh_alt  = (funct7[6:1] == F7_ALT[6:1]);

  always_comb begin
    op = OP_INVALID;
    case (opcode)
      LUI:   op = OP_LUI;
      AUIPC: op = OP_AUIPC;
      JAL:   op = OP_JAL;
      JALR:  if (funct3 == F3_ADD) op = OP_JALR;
      BRANCH: case (funct3)
        F3_BEQ:  op = OP_BEQ;
        F3_BNE:  op = OP_BNE;
        F3_BLT:  op = OP_BLT;
        F3_BGE:  op = OP_BGE;
        F3_BLTU: op = OP_BLTU;
        F3_BGEU: op = OP_BGEU;
        default: ;
      endcase
      LOAD: case (funct3)
        F3_B:  op = OP_LB;
        F3_H:  op = OP_LH;
        F3_W:  op = OP_LW;
        F3_D:  op = OP_LD;
        F3_BU: op = OP_LBU;
        F3_HU: op = OP_LHU;
        F3_WU: op = OP_LWU;
        default: ;
      endcase
      STORE: case (funct3)
        F3_B: op = OP_SB;
        F3_H: op = OP_SH;
        F3_W: op = OP_SW;
        F3_D: op = OP_SD;
        default: ;
      endcase
      OP_IMM: case (funct3)
        F3_ADD:  op = OP_ADDI;
        F3_SLT:  op = OP_SLTI;
        F3_SLTU: op = OP_SLTIU;
        F3_XOR:  op = OP_XORI;
        F3_OR:   op = OP_ORI;
        F3_AND:  op = OP_ANDI;
        F3_SLL:  if (sh_base) op = OP_SLLI;
        F3_SR: begin
          if (sh_base) op = OP_SRLI;
          else if (sh_alt) op = OP_SRAI;
        end
        default: ;
      endcase
      OP_IMM_32: case (funct3)
        F3_ADD: op = OP_ADDIW;
        F3_SLL: if (f7_base) op = OP_SLLIW;
        F3_SR: begin
          if (f7_base) op = OP_SRLIW;
          else if (f7_alt) op = OP_SRAIW;
        end
        default: ;
      endcase
      OP: case (funct3)
        F3_ADD: begin
          if (f7_base) op = OP_ADD;
          else if (f7_alt) op = OP_SUB;
        end
        F3_SLL:  if (f7_base) op = OP_SLL;
        F3_SLT:  if (f7_base) op = OP_SLT;
        F3_SLTU: if (f7_base) op = OP_SLTU;
        F3_XOR:  if (f7_base) op = OP_XOR;
        F3_SR: begin
          if (f7_base) op = OP_SRL;
          else if (f7_alt) op = OP_SRA;
        end
        F3_OR:   if (f7_base) op = OP_OR;
        F3_AND:  if (f7_base) op = OP_AND;
        default: ;
      endcase
      OP_32: case (funct3)
        F3_ADD: begin
          if (f7_base) op = OP_ADDW;
          else if (f7_alt) op = OP_SUBW;
        end
        F3_SLL: if (f7_base) op = OP_SLLW;
        F3_SR: begin
          if (f7_base) op = OP_SRLW;
          else if (f7_alt) op = OP_SRAW;
        end
        default: ;
      endcase
      default: ;
    endcase
    if (inst_g == '0) op = OP_NONE;
  end

  assign dec.op   = op;
  assign dec.rd   = inst_g[11:7];
  assign dec.rs1  = inst_g[19:15];
  assign dec.rs2  = inst_g[24:20];
  assign dec.inst = inst_g;

  assign o_invalid = (op == OP_INVALID);  // zero word is OP_NONE, never invalid

endmodule

/* verilog/isa_pkg.sv */
// rv64i isa package: opcodes, funct fields, widths and decoded instruction codes
package isa_pkg;

  localparam int XLEN       = 64;
  localparam int REG_ADDR_W = 5;
  localparam int INST_W     = 32;
  localparam int OPCODE_W   = 7;
  localparam int FUNCT3_W   = 3;
  localparam int FUNCT7_W   = 7;

  typedef enum logic [OPCODE_W-1:0] {
    LOAD      = 7'b0000011,
    STORE     = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_IMM_32 = 7'b0011011,
    OP        = 7'b0110011,
    OP_32     = 7'b0111011,
    LUI       = 7'b0110111,
    AUIPC     = 7'b0010111,
    JAL       = 7'b1101111,
    JALR      = 7'b1100111,
    BRANCH    = 7'b1100011
  } opcode_e;

  // alu group funct3
  localparam logic [FUNCT3_W-1:0] F3_ADD  = 3'b000;
  localparam logic [FUNCT3_W-1:0] F3_SLL  = 3'b001;
  localparam logic [FUNCT3_W-1:0] F3_SLT  = 3'b010;
  localparam logic [FUNCT3_W-1:0] F3_SLTU = 3'b011;
  localparam logic [FUNCT3_W-1:0] F3_XOR  = 3'b100;
  localparam logic [FUNCT3_W-1:0] F3_SR   = 3'b101;  // srl and sra
  localparam logic [FUNCT3_W-1:0] F3_OR   = 3'b110;
  localparam logic [FUNCT3_W-1:0] F3_AND  = 3'b111;

  // branch funct3
  localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'b000;
  localparam logic [FUNCT3_W-1:0] F3_BNE  = 3'b001;
  localparam logic [FUNCT3_W-1:0] F3_BLT  = 3'b100;
  localparam logic [FUNCT3_W-1:0] F3_BGE  = 3'b101;
  localparam logic [FUNCT3_W-1:0] F3_BLTU = 3'b110;
  localparam logic [FUNCT3_W-1:0] F3_BGEU = 3'b111;

  // load/store size funct3
  localparam logic [FUNCT3_W-1:0] F3_B  = 3'b000;
  localparam logic [FUNCT3_W-1:0] F3_H  = 3'b001;
  localparam logic [FUNCT3_W-1:0] F3_W  = 3'b010;
  localparam logic [FUNCT3_W-1:0] F3_D  = 3'b011;
  localparam logic [FUNCT3_W-1:0] F3_BU = 3'b100;
  localparam logic [FUNCT3_W-1:0] F3_HU = 3'b101;
  localparam logic [FUNCT3_W-1:0] F3_WU = 3'b110;

  localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;
  localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'b0100000;  // sub and arithmetic shifts

  typedef enum logic [5:0] {
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
    OP_SB, OP_SH, OP_SW, OP_SD,
    OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
    OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
    OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
    OP_NONE, OP_INVALID
  } inst_op_e;

endpackage
